//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = gtx_optical_rx_tb
FILELIST = tb.f
OBJ_DIR  = obj_dir
SIM      = $(OBJ_DIR)/V$(TOP)
PASS_MSG = Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/comparator_delay_line.sv
//----------------------------------------------------------------------------
// N-bx delay for comparator payloads, compensates cable length
//----------------------------------------------------------------------------
module comparator_delay_line #(
  parameter type payload_t = optical_rx_pkg::comp_data_t,  // Data or kchar payload
  parameter int  depth     = 16                             // Entries in the shift register
) (
  input  logic                     clock,
  input  logic                     gtx_rx_reset,
  input  optical_rx_pkg::delay_sel_t delay_is,   // Tap select, 0 gives 1 bx
  input  payload_t                 d,            // Payload in
  output payload_t                 q             // Payload from delay_is+1 bx ago
);
  import optical_rx_pkg::*;

  payload_t   shift_reg [depth];   // Entry k holds d from k+1 clocks back
  delay_sel_t tap_sel;             // Registered copy of delay_is

  //--------------------------------------------------------------------------
  // Tap selector, a new delay takes hold one clock after it changes
  //--------------------------------------------------------------------------
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      tap_sel <= '0;              // Minimum delay out of reset
    end else begin
      tap_sel <= delay_is;
    end
  end

  //--------------------------------------------------------------------------
  // Shift register, maps onto SRL primitives
  //--------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    shift_reg[0] <= d;            // Newest frame enters at the head
    for (int i = 1; i < depth; i++) begin
      shift_reg[i] <= shift_reg[i-1];
    end
  end

  assign q = shift_reg[tap_sel];  // Selected tap

endmodule

//--- hdl/fc_marker_monitor.sv
module fc_marker_monitor #(
  parameter int fc_period = optical_rx_pkg::FC_PERIOD_DEFAULT   // Clocks between markers
) (
  input  logic                   clock,
  input  logic                   gtx_rx_reset,
  input  logic                   rx_rst_done,    // Transceiver out of reset
  input  logic                   ttc_resync,     // Restart the lock search
  input  optical_rx_pkg::kchar_t kchar,          // Delayed k-characters
  output logic                   fc_marker_err,  // Marker early, late or missing
  output logic                   fc_locked       // First marker has been seen
);
  import optical_rx_pkg::*;

  localparam int                    cnt_bits = $clog2(fc_period);
  localparam logic [cnt_bits-1:0]   cnt_last = cnt_bits'(fc_period - 1);
  localparam logic [cnt_bits-1:0]   cnt_one  = cnt_bits'(1);

  logic                marker;     // FC pattern on the k-characters
  logic [cnt_bits-1:0] phase_cnt;  // Clocks since last marker modulo period
  logic                expect_fc;  // Marker due this clock

  assign marker = (kchar == FC_MARKER_KCHAR);

  //--------------------------------------------------------------------------
  // Phase counter, lock and error flag
  //--------------------------------------------------------------------------
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      phase_cnt     <= '0;
      expect_fc     <= 1'b0;
      fc_locked     <= 1'b0;
      fc_marker_err <= 1'b0;
    end else if (!rx_rst_done || ttc_resync) begin
      phase_cnt     <= '0;        // Start over and wait for a fresh marker
      expect_fc     <= 1'b0;
      fc_locked     <= 1'b0;
      fc_marker_err <= 1'b0;
    end else begin
      if (marker) begin
        phase_cnt <= cnt_one;     // Marker itself is phase zero
      end else if (phase_cnt == cnt_last) begin
        phase_cnt <= '0;          // Keep the period through a missing marker
      end else begin
        phase_cnt <= phase_cnt + cnt_one;
      end
      expect_fc <= !marker && (phase_cnt == cnt_last);   // Next clock should carry a marker
      if (marker) begin
        fc_locked <= 1'b1;        // Count errors only after the first marker
      end
      fc_marker_err <= fc_locked && (expect_fc != marker);
    end
  end

endmodule

//--- hdl/gtx_optical_rx.sv
//----------------------------------------------------------------------------
// Fabric side of one optical comparator receiver
//----------------------------------------------------------------------------
module gtx_optical_rx #(
  parameter int delay_depth = 16,                                // Max n-bx delay
  parameter int fc_period   = optical_rx_pkg::FC_PERIOD_DEFAULT  // FC marker spacing
) (
  input  logic                       clock,                // 40 MHz fabric clock
  input  logic                       gtx_rx_reset,
  input  logic                       clear_sync,           // Clears the status outputs
  input  logic                       ttc_resync,           // Clears the FC monitor
  input  optical_rx_pkg::delay_sel_t delay_is,             // Interstage delay
  input  logic                       gtx_rx_en_prbs_test,
  input  logic                       rx_rst_done,          // Transceiver flags
  input  logic                       rx_sync_done,
  input  logic                       link_good,
  input  logic                       link_bad,
  input  optical_rx_pkg::comp_data_t rx_data,              // Recovered frame
  input  optical_rx_pkg::kchar_t     rx_kchar,
  input  logic                       rx_valid,
  input  logic                       rx_match,
  input  logic                       rx_start,
  input  logic                       rx_fc,
  input  optical_rx_pkg::err_count_t link_err_count,
  output optical_rx_pkg::comp_data_t gtx_rx_data,          // Delayed comparator data
  output optical_rx_pkg::kchar_t     gtx_rx_kchar,         // Delayed k-characters
  output logic                       gtx_rx_start,
  output logic                       gtx_rx_fc,
  output logic                       gtx_rx_valid,
  output logic                       gtx_rx_match,
  output logic                       gtx_rx_sync_done,
  output logic                       gtx_rx_err,
  output optical_rx_pkg::err_count_t gtx_rx_err_count,
  output logic                       gtx_rx_rst_done,
  output logic                       fc_marker_err,        // Force-error into transceiver
  output logic                       fc_locked
);
  import optical_rx_pkg::*;

  link_frame_if frame ();        // Gated frame

  logic       prbs_err;          // PRBS checker results
  err_count_t prbs_err_count;

  link_frame_gate link_frame_gate_i (
    .clock, .gtx_rx_reset, .link_good, .link_bad,
    .rx_data, .rx_kchar, .rx_valid, .rx_match, .rx_start, .rx_fc,
    .frame (frame.source)
  );

  //--------------------------------------------------------------------------
  // N-bx delay, data and kchar share the selector
  //--------------------------------------------------------------------------
  comparator_delay_line #(.payload_t(comp_data_t), .depth(delay_depth)) data_delay_i (
    .clock, .gtx_rx_reset, .delay_is, .d(frame.data), .q(gtx_rx_data)
  );

  comparator_delay_line #(.payload_t(kchar_t), .depth(delay_depth)) kchar_delay_i (
    .clock, .gtx_rx_reset, .delay_is, .d(frame.kchar), .q(gtx_rx_kchar)
  );

  prbs_error_checker prbs_error_checker_i (
    .clock, .gtx_rx_reset, .rx_sync_done, .gtx_rx_en_prbs_test,
    .frame (frame.sink), .prbs_err, .prbs_err_count
  );

  fc_marker_monitor #(.fc_period(fc_period)) fc_marker_monitor_i (
    .clock, .gtx_rx_reset, .rx_rst_done, .ttc_resync,
    .kchar (gtx_rx_kchar), .fc_marker_err, .fc_locked
  );

  rx_status_register rx_status_register_i (
    .clock, .gtx_rx_reset, .clear_sync, .gtx_rx_en_prbs_test, .rx_sync_done, .rx_rst_done,
    .frame (frame.sink), .prbs_err, .prbs_err_count, .link_err_count,
    .gtx_rx_start, .gtx_rx_fc, .gtx_rx_valid, .gtx_rx_match,
    .gtx_rx_sync_done, .gtx_rx_rst_done, .gtx_rx_err, .gtx_rx_err_count
  );

endmodule

//--- hdl/link_frame_gate.sv
//----------------------------------------------------------------------------
// Frame capture with link gating
//----------------------------------------------------------------------------
module link_frame_gate (
  input  logic                       clock,
  input  logic                       gtx_rx_reset,
  input  logic                       link_good,   // Link monitor sees a clean link
  input  logic                       link_bad,    // Link monitor sees errors
  input  optical_rx_pkg::comp_data_t rx_data,     // Raw comparator data
  input  optical_rx_pkg::kchar_t     rx_kchar,    // Raw k-character flags
  input  logic                       rx_valid,
  input  logic                       rx_match,
  input  logic                       rx_start,
  input  logic                       rx_fc,
  link_frame_if.source               frame        // Gated frame out
);
  import optical_rx_pkg::*;

  logic ignore_link;   // Link cannot be trusted this clock

  // A noisy fiber would otherwise look like hot comparators
  assign ignore_link = !link_good || link_bad;

  //--------------------------------------------------------------------------
  // One clock of capture, payload zeroed on an unusable link
  //--------------------------------------------------------------------------
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      frame.data  <= '0;
      frame.kchar <= '0;
      frame.valid <= 1'b0;
      frame.match <= 1'b0;
      frame.start <= 1'b0;
      frame.fc    <= 1'b0;
    end else begin
      frame.data  <= ignore_link ? comp_data_t'('0) : rx_data;    // Suppress false hits
      frame.kchar <= ignore_link ? kchar_t'('0) : rx_kchar;       // No false FC markers
      frame.valid <= rx_valid;    // Flags pass ungated
      frame.match <= rx_match;
      frame.start <= rx_start;
      frame.fc    <= rx_fc;
    end
  end

endmodule

//--- hdl/link_frame_if.sv
//----------------------------------------------------------------------------
// One gated frame and its flags, one frame per clock
//----------------------------------------------------------------------------
interface link_frame_if;
  import optical_rx_pkg::*;

  comp_data_t data;    // Comparator data, zero while link unusable
  kchar_t     kchar;   // K-character flags, gated with data
  logic       valid;   // Link reports valid data
  logic       match;   // PRBS pattern matched
  logic       start;   // Start pattern seen
  logic       fc;      // FC code seen by the transceiver

  // Gate drives the frame
  modport source (output data, kchar, valid, match, start, fc);

  // Checkers and status logic read it
  modport sink (input data, kchar, valid, match, start, fc);

endinterface

//--- hdl/optical_rx_pkg.sv
//----------------------------------------------------------------------------
// Frame types and link constants for the optical comparator receiver
//----------------------------------------------------------------------------
package optical_rx_pkg;

  // Field widths of one recovered frame
  localparam int COMP_DATA_BITS = 48;          // Comparator bits per bx
  localparam int KCHAR_BITS     = 16;          // One k-flag per received byte
  localparam int ERR_COUNT_BITS = 16;          // Width of every error counter
  localparam int DELAY_SEL_BITS = 4;           // Selects 1 to 16 bx of delay

  typedef logic [COMP_DATA_BITS-1:0] comp_data_t;   // One bx of comparator data
  typedef logic [KCHAR_BITS-1:0]     kchar_t;       // K-character flags of a frame
  typedef logic [ERR_COUNT_BITS-1:0] err_count_t;   // Wrapping error count
  typedef logic [DELAY_SEL_BITS-1:0] delay_sel_t;   // N-bx delay selector

  //--------------------------------------------------------------------------
  // Link constants
  //--------------------------------------------------------------------------
  // The transmitter inserts this k-character pattern for latency checks
  localparam kchar_t FC_MARKER_KCHAR = 16'h50FC;

  // Clocks between two FC markers on a healthy link
  localparam int FC_PERIOD_DEFAULT = 128;

  // Only the low byte of an error count goes to the results register
  localparam int ERR_COUNT_REPORTED_BITS = 8;

endpackage

//--- hdl/prbs_error_checker.sv
//----------------------------------------------------------------------------
// PRBS error checker on the gated frame
//----------------------------------------------------------------------------
module prbs_error_checker (
  input  logic                       clock,
  input  logic                       gtx_rx_reset,
  input  logic                       rx_sync_done,         // Transceiver sync complete
  input  logic                       gtx_rx_en_prbs_test,  // Random test pattern mode
  link_frame_if.sink                 frame,                // Gated frame in
  output logic                       prbs_err,             // Last judged frame failed
  output optical_rx_pkg::err_count_t prbs_err_count        // Wrapping mismatch count
);
  import optical_rx_pkg::*;

  logic judge;     // Frame counts toward the test
  logic mismatch;  // Valid says it should match, but it does not

  assign judge    = gtx_rx_en_prbs_test && rx_sync_done;
  assign mismatch = frame.valid && !frame.match;

  //--------------------------------------------------------------------------
  // Error flag and counter
  //--------------------------------------------------------------------------
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      prbs_err       <= 1'b0;
      prbs_err_count <= '0;
    end else if (!rx_sync_done) begin
      prbs_err       <= 1'b0;     // Hold cleared until link syncs
      prbs_err_count <= '0;
    end else if (judge) begin
      if (mismatch) begin
        prbs_err       <= 1'b1;                                  // Scope or LED visible
        prbs_err_count <= prbs_err_count + err_count_t'(1);      // Wraps at full scale
      end else begin
        prbs_err <= 1'b0;
      end
    end
  end

endmodule

//--- hdl/rx_status_register.sv
//----------------------------------------------------------------------------
// Receiver status register on the fabric clock
//----------------------------------------------------------------------------
module rx_status_register (
  input  logic                       clock,
  input  logic                       gtx_rx_reset,
  input  logic                       clear_sync,           // Zeroes all status outputs
  input  logic                       gtx_rx_en_prbs_test,  // Selects the reported count
  input  logic                       rx_sync_done,
  input  logic                       rx_rst_done,
  link_frame_if.sink                 frame,                // Gated frame flags
  input  logic                       prbs_err,
  input  optical_rx_pkg::err_count_t prbs_err_count,
  input  optical_rx_pkg::err_count_t link_err_count,       // From the link monitor
  output logic                       gtx_rx_start,         // Start pattern present
  output logic                       gtx_rx_fc,            // FC code for latency checks
  output logic                       gtx_rx_valid,         // Valid data on the link
  output logic                       gtx_rx_match,         // PRBS data matched
  output logic                       gtx_rx_sync_done,     // Needed before gtx is ready
  output logic                       gtx_rx_rst_done,      // Precedes rx sync
  output logic                       gtx_rx_err,           // PRBS error seen
  output optical_rx_pkg::err_count_t gtx_rx_err_count      // Low byte of selected count
);
  import optical_rx_pkg::*;

  err_count_t selected_count;   // PRBS count in test mode, link count otherwise

  assign selected_count = gtx_rx_en_prbs_test ? prbs_err_count : link_err_count;

  //--------------------------------------------------------------------------
  // Status outputs
  //--------------------------------------------------------------------------
  always_ff @(posedge clock or posedge gtx_rx_reset) begin
    if (gtx_rx_reset) begin
      gtx_rx_start     <= 1'b0;
      gtx_rx_fc        <= 1'b0;
      gtx_rx_valid     <= 1'b0;
      gtx_rx_match     <= 1'b0;
      gtx_rx_sync_done <= 1'b0;
      gtx_rx_rst_done  <= 1'b0;
      gtx_rx_err       <= 1'b0;
      gtx_rx_err_count <= '0;
    end else if (clear_sync) begin
      gtx_rx_start     <= 1'b0;
      gtx_rx_fc        <= 1'b0;
      gtx_rx_valid     <= 1'b0;
      gtx_rx_match     <= 1'b0;
      gtx_rx_sync_done <= 1'b0;
      gtx_rx_rst_done  <= 1'b0;
      gtx_rx_err       <= 1'b0;
      gtx_rx_err_count <= '0;
    end else begin
      gtx_rx_start     <= frame.start;
      gtx_rx_fc        <= frame.fc;
      gtx_rx_valid     <= frame.valid;
      gtx_rx_match     <= frame.match;
      gtx_rx_sync_done <= rx_sync_done;
      gtx_rx_rst_done  <= rx_rst_done;
      gtx_rx_err       <= prbs_err;
      // Upper bits read as zero
      gtx_rx_err_count <= err_count_t'(selected_count[ERR_COUNT_REPORTED_BITS-1:0]);
    end
  end

endmodule

//--- tb.f
hdl/optical_rx_pkg.sv
hdl/link_frame_if.sv
hdl/comparator_delay_line.sv
hdl/link_frame_gate.sv
hdl/prbs_error_checker.sv
hdl/fc_marker_monitor.sv
hdl/rx_status_register.sv
hdl/gtx_optical_rx.sv
testbench/gtx_optical_rx_tb.sv

//--- testbench/gtx_optical_rx_tb.sv
module gtx_optical_rx_tb;
  import optical_rx_pkg::*;

  typedef logic [63:0] word_t;   // Step kind token from the vectors file

  logic       clock, gtx_rx_reset, clear_sync, ttc_resync;
  delay_sel_t delay_is;
  logic       gtx_rx_en_prbs_test, rx_rst_done, rx_sync_done, link_good, link_bad;
  comp_data_t rx_data, gtx_rx_data;
  kchar_t     rx_kchar, gtx_rx_kchar;
  logic       rx_valid, rx_match, rx_start, rx_fc;
  err_count_t link_err_count, gtx_rx_err_count;
  logic       gtx_rx_start, gtx_rx_fc, gtx_rx_valid, gtx_rx_match, gtx_rx_sync_done;
  logic       gtx_rx_err, gtx_rx_rst_done, fc_marker_err, fc_locked;
  int         cur_lat;                 // Clocks from driven frame to delayed output

  gtx_optical_rx gtx_optical_rx_i (.*);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;         // Period 10
  end

  //--------------------------------------------------------------------------
  // Compare tasks
  //--------------------------------------------------------------------------
  task automatic stop_on_error();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input comp_data_t got, input comp_data_t exp);
    if (got !== exp) begin
      $display("Error: %s is %h, expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_kchar(input string name, input kchar_t got, input kchar_t exp);
    if (got !== exp) begin
      $display("Error: %s is %h, expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_count(input string name, input err_count_t got, input err_count_t exp);
    if (got !== exp) begin
      $display("Error: %s is %h, expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_flag(input string name, input bit got, input bit exp);
    if (got !== exp) begin
      $display("Error: %s is %h, expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic verify_vector(input int file_val, input int rule_val);
    if (file_val != rule_val) begin
      $display("Vectors file expects %0h where the receiver rules give %0h", file_val, rule_val);
      stop_on_error();
    end
  endtask

  task automatic next_clock();
    @(posedge clock);
    #1;                                // Sample and then drive just after the edge
  endtask

  task automatic check_status_zero();  // Everything reset and clear_sync zero
    check_flag("gtx_rx_start", gtx_rx_start, 1'b0);
    check_flag("gtx_rx_fc", gtx_rx_fc, 1'b0);
    check_flag("gtx_rx_valid", gtx_rx_valid, 1'b0);
    check_flag("gtx_rx_match", gtx_rx_match, 1'b0);
    check_flag("gtx_rx_sync_done", gtx_rx_sync_done, 1'b0);
    check_flag("gtx_rx_rst_done", gtx_rx_rst_done, 1'b0);
    check_flag("gtx_rx_err", gtx_rx_err, 1'b0);
    check_count("gtx_rx_err_count", gtx_rx_err_count, '0);
  endtask

  //--------------------------------------------------------------------------
  // Steps of the vectors file
  //--------------------------------------------------------------------------
  task automatic apply_reset();
    gtx_rx_reset = 1'b1;
    repeat (2) next_clock();
    gtx_rx_reset = 1'b0;
    check_status_zero();
    check_flag("fc_marker_err", fc_marker_err, 1'b0);
    check_flag("fc_locked", fc_locked, 1'b0);
    rx_rst_done  = 1'b1;               // Transceiver up and synced on a clean link
    rx_sync_done = 1'b1;
    link_good    = 1'b1;
  endtask

  // One random frame and idle clocks until it leaves the delay line
  task automatic send_frame(input bit pass);
    comp_data_t d;
    kchar_t     k;
    d = comp_data_t'({$urandom, $urandom});
    k = kchar_t'($urandom);
    if (k == FC_MARKER_KCHAR) begin
      k = ~k;                          // Keep the FC monitor out of it
    end
    rx_data  = d;
    rx_kchar = k;
    rx_valid = 1'b1;
    for (int c = 1; c <= cur_lat; c++) begin
      next_clock();
      rx_data  = '0;
      rx_kchar = '0;
      rx_valid = 1'b0;
      check_data("gtx_rx_data", gtx_rx_data, (c == cur_lat && pass) ? d : '0);
      check_kchar("gtx_rx_kchar", gtx_rx_kchar, (c == cur_lat && pass) ? k : '0);
      check_flag("gtx_rx_valid", gtx_rx_valid, c == 2);   // Flags bypass the delay
    end
  endtask

  task automatic measure_delay(input int sel, input int frames, input int exp);
    verify_vector(exp, sel + 2);
    delay_is = delay_sel_t'(sel);
    cur_lat  = sel + 2;                // Gate register plus sel+1 taps
    repeat (20) next_clock();          // New tap and an empty line
    repeat (frames) send_frame(1'b1);
  endtask

  task automatic gate_link(input int good, input int bad, input int frames, input int exp);
    bit pass;
    pass = (good == 1) && (bad == 0);
    verify_vector(exp, int'(pass));
    link_good = good[0];
    link_bad  = bad[0];
    repeat (frames) send_frame(pass);
    link_good = 1'b1;
    link_bad  = 1'b0;
  endtask

  task automatic count_prbs_errors(input int en, input int link_cnt, input int frames,
                                   input int exp);
    int rule;
    rule = en ? frames % 256 : link_cnt % 256;   // Only the low byte is reported
    verify_vector(exp, rule);
    gtx_rx_en_prbs_test = en[0];
    link_err_count      = err_count_t'(link_cnt);
    rx_sync_done        = 1'b0;        // Restarts the PRBS count
    next_clock();
    rx_sync_done = 1'b1;
    repeat (frames) begin
      rx_valid = 1'b1;                 // Valid without match
      next_clock();
    end
    rx_valid = 1'b0;
    repeat (2) next_clock();           // Checker and then status register
    check_count("gtx_rx_err_count", gtx_rx_err_count, err_count_t'(rule));
    check_flag("gtx_rx_err", gtx_rx_err, en[0]);
    gtx_rx_en_prbs_test = 1'b0;
  endtask

  task automatic track_fc_markers(input int omit, input int periods, input int exp);
    int j;
    bit err_seen;
    verify_vector(exp, omit);
    ttc_resync = 1'b1;
    next_clock();
    ttc_resync = 1'b0;
    check_flag("fc_locked", fc_locked, 1'b0);
    err_seen = 1'b0;
    for (j = 0; j < periods * FC_PERIOD_DEFAULT; j++) begin
      // Second marker left out when omit is set
      rx_kchar = (j % FC_PERIOD_DEFAULT == 0 && !(omit && j == FC_PERIOD_DEFAULT)) ?
                 FC_MARKER_KCHAR : '0;
      next_clock();
      err_seen |= fc_marker_err;
      if (j == 40 && !fc_locked) begin
        $display("Timeout waiting for fc_locked after the first marker");
        stop_on_error();
      end
    end
    rx_kchar = '0;
    check_flag("fc_locked", fc_locked, 1'b1);
    check_flag("fc_marker_err seen", err_seen, omit[0]);
    ttc_resync = 1'b1;                 // Drop the lock before markers go missing
    next_clock();
    ttc_resync = 1'b0;
    check_flag("fc_locked", fc_locked, 1'b0);
    check_flag("fc_marker_err", fc_marker_err, 1'b0);
  endtask

  task automatic clear_status();
    rx_valid       = 1'b1;
    rx_match       = 1'b1;
    rx_start       = 1'b1;
    rx_fc          = 1'b1;
    link_err_count = 16'h00a5;
    repeat (3) next_clock();
    check_flag("gtx_rx_start", gtx_rx_start, 1'b1);
    check_flag("gtx_rx_fc", gtx_rx_fc, 1'b1);
    check_flag("gtx_rx_valid", gtx_rx_valid, 1'b1);
    check_flag("gtx_rx_match", gtx_rx_match, 1'b1);
    check_flag("gtx_rx_sync_done", gtx_rx_sync_done, 1'b1);
    check_flag("gtx_rx_rst_done", gtx_rx_rst_done, 1'b1);
    check_count("gtx_rx_err_count", gtx_rx_err_count, 16'h00a5);
    clear_sync = 1'b1;
    next_clock();
    check_status_zero();               // One clock after clear_sync
    clear_sync = 1'b0;
    rx_valid   = 1'b0;
    rx_match   = 1'b0;
    rx_start   = 1'b0;
    rx_fc      = 1'b0;
  endtask

  //--------------------------------------------------------------------------
  // Vector loop
  //--------------------------------------------------------------------------
  initial begin
    int            fd;
    word_t         kind;
    int            a, b, cnt, exp;
    logic [1023:0] rest;
    gtx_rx_reset = 1'b1;
    clear_sync = 1'b0;
    ttc_resync = 1'b0;
    delay_is = '0;
    gtx_rx_en_prbs_test = 1'b0;
    rx_rst_done = 1'b0;
    rx_sync_done = 1'b0;
    link_good = 1'b0;
    link_bad = 1'b0;
    rx_data = '0;
    rx_kchar = '0;
    rx_valid = 1'b0;
    rx_match = 1'b0;
    rx_start = 1'b0;
    rx_fc = 1'b0;
    link_err_count = '0;
    cur_lat = 2;
    void'($urandom(11602));
    fd = $fopen("testbench/gtx_optical_rx_vectors.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the vectors file");
      stop_on_error();
    end
    while ($fscanf(fd, "%s", kind) == 1) begin
      if (kind == word_t'("#")) begin
        void'($fgets(rest, fd));       // Column notes
      end else begin
        void'($fscanf(fd, "%h %h %h %h", a, b, cnt, exp));
        if (kind == word_t'("reset")) apply_reset();
        else if (kind == word_t'("delay")) measure_delay(a, cnt, exp);
        else if (kind == word_t'("gate")) gate_link(a, b, cnt, exp);
        else if (kind == word_t'("prbs")) count_prbs_errors(a, b, cnt, exp);
        else if (kind == word_t'("fc")) track_fc_markers(a, cnt, exp);
        else if (kind == word_t'("clear")) clear_status();
        else begin
          $display("Unknown step kind in the vectors file");
          stop_on_error();
        end
      end
    end
    $fclose(fd);
    $display("Testbench passed");
    $finish;
  end

endmodule

//--- testbench/gtx_optical_rx_vectors.txt
# kind a b count expect, numbers in hex. delay: a=delay_is, expect=latency. gate: a=good b=bad
# prbs: a=enable b=link_err_count, expect=count. fc: a=omit marker, count=periods, expect=err
reset 0 0 0 0
delay 0 0 4 2
delay 5 0 4 7
delay f 0 4 11
gate 1 0 3 1
gate 0 0 3 0
gate 1 1 3 0
gate 0 1 3 0
prbs 1 0 5 5
prbs 1 0 12c 2c
prbs 0 1234 8 34
prbs 0 ffab 3 ab
fc 0 0 4 0
fc 1 0 4 1
clear 0 0 0 0
